// ==== vlog.f ====
+incdir+common
common/rv64_isa_pkg.sv
common/be_types_pkg.sv
design/be_predecode.sv
design/mem_1r1w.sv
issue_queue/be_issue_queue.sv
design/be_issue_top.sv
sim/tb_be_issue_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the testbench with Verilator and runs it; the exit status is the result
set -e
cd "$(dirname "$0")"
verilator --binary --assert --timing -f vlog.f --top-module tb_be_issue_top -Mdir obj_dir
./obj_dir/Vtb_be_issue_top

// ==== sim/tb_be_issue_top.sv ====
`timescale 1ns/1ps

`include "be_config.svh"

module tb_be_issue_top;

  import be_types_pkg::*;

  localparam int els_lp         = `BE_QUEUE_ELS;
  localparam int vaddr_width_lp = `BE_VADDR_WIDTH;
  localparam int rows_lp        = 16;
  localparam int entries_lp     = 2 * rows_lp; // the table goes through the queue twice

  localparam logic [vaddr_width_lp-1:0] pc_base_lp = 'h8000_0000;

  // one table row is an instruction word, its message kind and the packet it must give
  typedef struct packed {
    logic [31:0]   instr;
    be_msg_e       msg;
    be_issue_pkt_s pkt;
  } row_s;

  logic                      clk = 1'b0;
  logic                      reset;
  logic                      fe_v;
  logic                      yumi;
  logic                      deq_v;
  logic                      roll_v;
  logic                      clr_v;
  logic [vaddr_width_lp-1:0] fe_pc;
  logic [31:0]               fe_instr;
  be_msg_e                   fe_msg;
  logic                      fe_ready;
  logic                      q_v;
  logic [vaddr_width_lp-1:0] q_pc;
  logic [31:0]               q_instr;
  be_msg_e                   q_msg;
  be_issue_pkt_s             preissue_pkt;
  be_issue_pkt_s             issue_pkt;

  row_s                      tbl[$];
  logic [vaddr_width_lp-1:0] hist_pc[$];  // model entries, indexed by absolute write count
  int                        hist_row[$];
  int                        r, c, w;     // model read, commit and write counts
  int                        seq, cyc, n_replay, n_drop;
  logic                      enq, saw_full, pkt_known;
  be_issue_pkt_s             exp_pkt;
  logic [31:0]               rng;

  always #4 clk = ~clk;

  be_issue_top UUT
    (.clk_i(clk), .reset_i(reset)
    ,.fe_v_i(fe_v), .fe_pc_i(fe_pc), .fe_instr_i(fe_instr), .fe_msg_i(fe_msg)
    ,.fe_ready_o(fe_ready)
    ,.fe_queue_v_o(q_v), .fe_queue_pc_o(q_pc), .fe_queue_instr_o(q_instr)
    ,.fe_queue_msg_o(q_msg), .fe_queue_yumi_i(yumi)
    ,.deq_v_i(deq_v), .roll_v_i(roll_v), .clr_v_i(clr_v)
    ,.preissue_pkt_o(preissue_pkt), .issue_pkt_o(issue_pkt)
    );

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic check(input logic [63:0] got, input logic [63:0] exp, input string what);
    if (got !== exp)
    begin
      $display("error at %0t: %s is %0h, expected %0h", $time, what, got, exp);
      $display(">>> FAIL");
      $fatal(1, "mismatch on %s", what);
    end
  endtask

  //////////////////////////////
  // reference queue

  // moves the model across the edge that just passed
  task automatic step_model();
    int c_n;
    int r_n;
    int w_n;
    enq = fe_v && !clr_v && (w - c < els_lp);
    if (enq && w < hist_pc.size())
    begin
      hist_pc[w]  = fe_pc; // slot reused after a clear
      hist_row[w] = seq % rows_lp;
    end
    else if (enq)
    begin
      hist_pc.push_back(fe_pc);
      hist_row.push_back(seq % rows_lp);
    end
    c_n = c + (deq_v ? 1 : 0);
    r_n = roll_v ? c_n : r + (yumi ? 1 : 0);
    w_n = clr_v ? r_n : w + (enq ? 1 : 0);
    if (roll_v && r > c_n)
      n_replay++;
    if (clr_v && w > r_n)
      n_drop++;
    if ((yumi && r_n != w_n) || roll_v || (enq && r == w))
    begin
      pkt_known = (r_n < w_n); // a roll onto an empty queue captures whatever fetch shows
      if (pkt_known)
        exp_pkt = tbl[hist_row[r_n]].pkt;
    end
    if (enq)
      seq++;
    c = c_n;
    r = r_n;
    w = w_n;
    if (w - c == els_lp)
      saw_full = 1'b1;
  endtask

  task automatic drive_inputs();
    logic hold;
    hold = fe_v && !enq; // a stalled fetch entry stays on the bus
    rng  = lcg_next(rng);
    if (cyc < 16)
    begin
      // fill phase reads everything and commits nothing
      roll_v <= 1'b0;
      clr_v  <= 1'b0;
      deq_v  <= 1'b0;
      yumi   <= (r < w);
      fe_v   <= hold || (seq < entries_lp);
    end
    else
    begin
      roll_v <= (rng[31:29] == 3'd0);
      clr_v  <= (rng[31:28] == 4'd2);
      deq_v  <= (c < r) && rng[25];
      yumi   <= (rng[31:29] != 3'd0) && (r < w) && (rng[24] || rng[23]);
      fe_v   <= hold || ((seq < entries_lp) && (rng[22:21] != 2'd0));
    end
    fe_pc    <= pc_base_lp + vaddr_width_lp'(seq * 4);
    fe_instr <= tbl[seq % rows_lp].instr;
    fe_msg   <= tbl[seq % rows_lp].msg;
  endtask

  task automatic check_outputs();
    int   c_nx;
    int   r_nx;
    logic enq_nx;
    c_nx   = c + (deq_v ? 1 : 0);
    r_nx   = roll_v ? c_nx : r + (yumi ? 1 : 0);
    enq_nx = fe_v && !clr_v && (w - c < els_lp);
    check(64'(fe_ready), 64'(!clr_v && (w - c < els_lp)), "fe_ready_o");
    check(64'(q_v), 64'(!roll_v && (r < w)), "fe_queue_v_o");
    if (!roll_v && r < w)
    begin
      check(64'(q_pc), 64'(hist_pc[r]), "fe_queue_pc_o");
      check(64'(q_instr), 64'(tbl[hist_row[r]].instr), "fe_queue_instr_o");
      check(64'(q_msg), 64'(tbl[hist_row[r]].msg), "fe_queue_msg_o");
    end
    // head after the coming edge, which may be the entry now on the fetch bus
    if (r_nx < w)
      check(64'(preissue_pkt), 64'(tbl[hist_row[r_nx]].pkt), "preissue_pkt_o");
    else if (r_nx == w && enq_nx)
      check(64'(preissue_pkt), 64'(tbl[seq % rows_lp].pkt), "preissue_pkt_o");
    if (pkt_known)
      check(64'(issue_pkt), 64'(exp_pkt), "issue_pkt_o");
  endtask

  //////////////////////////////
  // stimulus

  initial
  begin
    reset     = 1'b1;
    fe_v      = 1'b0;
    fe_pc     = '0;
    fe_instr  = '0;
    fe_msg    = e_instr_fetch;
    yumi      = 1'b0;
    deq_v     = 1'b0;
    roll_v    = 1'b0;
    clr_v     = 1'b0;
    rng       = 32'hda76244a;
    saw_full  = 1'b0;
    pkt_known = 1'b1; // issue register resets to zero
    exp_pkt   = '0;

    // packet flags are csr mem fence long irs1 irs2 frs1 frs2 frs3, then rs1 rs2 rs3
    tbl.push_back({32'h002081b3, e_instr_fetch, 9'b000011000, 5'd1, 5'd2, 5'd0});
    tbl.push_back({32'h027342b3, e_instr_fetch, 9'b000111000, 5'd6, 5'd7, 5'd0}); // div
    tbl.push_back({32'h023110b3, e_instr_fetch, 9'b000111000, 5'd2, 5'd3, 5'd0}); // mulh
    tbl.push_back({32'h023100b3, e_instr_fetch, 9'b000011000, 5'd2, 5'd3, 5'd0});
    tbl.push_back({32'h0085b503, e_instr_fetch, 9'b010010000, 5'd11, 5'd8, 5'd0});
    tbl.push_back({32'h00c6b823, e_instr_fetch, 9'b010011000, 5'd13, 5'd12, 5'd0});
    tbl.push_back({32'h0042b027, e_instr_fetch, 9'b010010010, 5'd5, 5'd4, 5'd0}); // fsd
    tbl.push_back({32'h223100c3, e_instr_fetch, 9'b000000111, 5'd2, 5'd3, 5'd4});
    tbl.push_back({32'h1a7302d3, e_instr_fetch, 9'b000100110, 5'd6, 5'd7, 5'd3}); // fdiv
    tbl.push_back({32'h5a0100d3, e_instr_fetch, 9'b000100100, 5'd2, 5'd0, 5'd11});
    tbl.push_back({32'hd22480d3, e_instr_fetch, 9'b000010000, 5'd9, 5'd2, 5'd26});
    tbl.push_back({32'h300110f3, e_instr_fetch, 9'b110010000, 5'd2, 5'd0, 5'd6}); // csrrw
    tbl.push_back({32'h0ff0000f, e_instr_fetch, 9'b001000000, 5'd0, 5'd31, 5'd1});
    tbl.push_back({32'h12208073, e_instr_fetch, 9'b111010000, 5'd1, 5'd2, 5'd2});
    tbl.push_back({32'h002081b3, e_exception, 9'b000000000, 5'd0, 5'd0, 5'd0});
    tbl.push_back({32'h027342b3, e_itlb_fill, 9'b000000000, 5'd0, 5'd0, 5'd0});

    repeat (8) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    check_outputs();

    while (!(seq == entries_lp && c == w))
    begin
      @(posedge clk);
      step_model();
      drive_inputs();
      cyc++;
      @(negedge clk);
      check_outputs();
    end

    if (saw_full && n_replay > 0 && n_drop > 0)
    begin
      $display(">>> PASS");
      $finish;
    end
    else
    begin
      $display("the run never filled the queue, replayed after a roll or flushed on a clear");
      $display(">>> FAIL");
      $fatal(1, "stimulus too weak");
    end
  end

  initial
  begin
    repeat (rows_lp * 40) @(posedge clk);
    $display("timeout: the queue did not drain within %0d cycles", rows_lp * 40);
    $display(">>> FAIL");
    $fatal(1, "watchdog expired");
  end

endmodule

// ==== design/be_issue_top.sv ====
`timescale 1ns/1ps

`include "be_config.svh"

module be_issue_top
  (input  logic                          clk_i
  ,input  logic                          reset_i

  ,input  logic                          fe_v_i
  ,input  logic [`BE_VADDR_WIDTH-1:0]    fe_pc_i
  ,input  logic [31:0]                   fe_instr_i
  ,input  be_types_pkg::be_msg_e         fe_msg_i
  ,output logic                          fe_ready_o

  ,output logic                          fe_queue_v_o
  ,output logic [`BE_VADDR_WIDTH-1:0]    fe_queue_pc_o
  ,output logic [31:0]                   fe_queue_instr_o
  ,output be_types_pkg::be_msg_e         fe_queue_msg_o
  ,input  logic                          fe_queue_yumi_i

  ,input  logic                          deq_v_i
  ,input  logic                          roll_v_i
  ,input  logic                          clr_v_i

  ,output be_types_pkg::be_issue_pkt_s   preissue_pkt_o
  ,output be_types_pkg::be_issue_pkt_s   issue_pkt_o
  );

  import be_types_pkg::*;

  be_issue_pkt_s fe_pkt; // enq in the queue qualifies it

  be_predecode predecode
    (.msg_i(fe_msg_i)
    ,.instr_i(fe_instr_i)
    ,.pkt_o(fe_pkt)
    );

  be_issue_queue queue
    (.clk_i(clk_i)
    ,.reset_i(reset_i)
    ,.clr_v_i(clr_v_i)
    ,.deq_v_i(deq_v_i)
    ,.roll_v_i(roll_v_i)
    ,.fe_v_i(fe_v_i)
    ,.fe_pc_i(fe_pc_i)
    ,.fe_instr_i(fe_instr_i)
    ,.fe_msg_i(fe_msg_i)
    ,.fe_pkt_i(fe_pkt)
    ,.fe_ready_o(fe_ready_o)
    ,.fe_queue_v_o(fe_queue_v_o)
    ,.fe_queue_pc_o(fe_queue_pc_o)
    ,.fe_queue_instr_o(fe_queue_instr_o)
    ,.fe_queue_msg_o(fe_queue_msg_o)
    ,.fe_queue_yumi_i(fe_queue_yumi_i)
    ,.preissue_pkt_o(preissue_pkt_o)
    ,.issue_pkt_o(issue_pkt_o)
    );

endmodule

// ==== issue_queue/be_issue_queue.sv ====
`timescale 1ns/1ps

`include "be_config.svh"

module be_issue_queue
  (input  logic                          clk_i
  ,input  logic                          reset_i

  ,input  logic                          clr_v_i
  ,input  logic                          deq_v_i
  ,input  logic                          roll_v_i

  ,input  logic                          fe_v_i
  ,input  logic [`BE_VADDR_WIDTH-1:0]    fe_pc_i
  ,input  logic [31:0]                   fe_instr_i
  ,input  be_types_pkg::be_msg_e         fe_msg_i
  ,input  be_types_pkg::be_issue_pkt_s   fe_pkt_i
  ,output logic                          fe_ready_o

  ,output logic                          fe_queue_v_o
  ,output logic [`BE_VADDR_WIDTH-1:0]    fe_queue_pc_o
  ,output logic [31:0]                   fe_queue_instr_o
  ,output be_types_pkg::be_msg_e         fe_queue_msg_o
  ,input  logic                          fe_queue_yumi_i

  ,output be_types_pkg::be_issue_pkt_s   preissue_pkt_o
  ,output be_types_pkg::be_issue_pkt_s   issue_pkt_o
  );

  import be_types_pkg::*;

  localparam int ptr_width_lp = `BE_PTR_WIDTH;

  // index plus one wrap bit
  typedef logic [ptr_width_lp:0] ptr_t;

  typedef struct packed {
    logic [`BE_VADDR_WIDTH-1:0] pc;
    logic [31:0]                instr;
    be_msg_e                    msg;
  } fe_entry_s;

  ptr_t wptr_r, rptr_r, cptr_r;
  ptr_t wptr_n, rptr_n, cptr_n;

  logic enq, read, empty, full, issue_v, bypass;

  fe_entry_s     fe_entry_li, fe_entry_lo;
  be_issue_pkt_s pkt_mem_lo;

  //////////////////////////////
  // pointers

  assign enq  = fe_v_i & fe_ready_o;
  assign read = fe_queue_yumi_i;

  assign cptr_n = cptr_r + ptr_t'(deq_v_i);
  assign rptr_n = roll_v_i ? cptr_n : (rptr_r + ptr_t'(read)); // roll replays from commit
  assign wptr_n = clr_v_i ? rptr_n : (wptr_r + ptr_t'(enq));   // clear drops unread entries

  assign empty = (rptr_r == wptr_r);
  // read but uncommitted entries still hold their slot
  assign full  = (cptr_r == {~wptr_r[ptr_width_lp], wptr_r[ptr_width_lp-1:0]});

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      wptr_r <= '0;
      rptr_r <= '0;
      cptr_r <= '0;
    end
    else
    begin
      wptr_r <= wptr_n;
      rptr_r <= rptr_n;
      cptr_r <= cptr_n;
    end
  end

  assign fe_queue_v_o = ~roll_v_i & ~empty;
  assign fe_ready_o   = ~clr_v_i & ~full;

  //////////////////////////////
  // entry storage

  assign fe_entry_li.pc    = fe_pc_i;
  assign fe_entry_li.instr = fe_instr_i;
  assign fe_entry_li.msg   = fe_msg_i;

  mem_1r1w
    #(.data_t(fe_entry_s)
    ,.els_p(`BE_QUEUE_ELS)
    )
    fe_mem
    (.clk_i(clk_i)
    ,.w_v_i(enq)
    ,.w_addr_i(wptr_r[ptr_width_lp-1:0])
    ,.w_data_i(fe_entry_li)
    ,.r_addr_i(rptr_r[ptr_width_lp-1:0])
    ,.r_data_o(fe_entry_lo)
    );

  assign fe_queue_pc_o    = fe_entry_lo.pc;
  assign fe_queue_instr_o = fe_entry_lo.instr;
  assign fe_queue_msg_o   = fe_entry_lo.msg;

  //////////////////////////////
  // issue packets

  mem_1r1w
    #(.data_t(be_issue_pkt_s)
    ,.els_p(`BE_QUEUE_ELS)
    )
    pkt_mem
    (.clk_i(clk_i)
    ,.w_v_i(enq)
    ,.w_addr_i(wptr_r[ptr_width_lp-1:0])
    ,.w_data_i(fe_pkt_i)
    ,.r_addr_i(rptr_n[ptr_width_lp-1:0])
    ,.r_data_o(pkt_mem_lo)
    );

  // the next head is the entry being written this cycle
  assign bypass         = (rptr_n == wptr_r);
  assign preissue_pkt_o = bypass ? fe_pkt_i : pkt_mem_lo;

  assign issue_v = (read & (rptr_n != wptr_n)) | roll_v_i | (enq & empty);

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      issue_pkt_o <= '0;
    else if (issue_v)
      issue_pkt_o <= preissue_pkt_o;
  end

  //////////////////////////////
  // checks

  a_yumi_v: assert property (@(posedge clk_i) disable iff (reset_i)
                             fe_queue_yumi_i |-> fe_queue_v_o)
    else $error("consumer took an entry that was not valid");

  a_deq_read: assert property (@(posedge clk_i) disable iff (reset_i)
                               deq_v_i |-> (cptr_r != rptr_r))
    else $error("commit of an entry that was never read");

  a_roll_clr: assert property (@(posedge clk_i) disable iff (reset_i)
                               !(roll_v_i && clr_v_i))
    else $error("roll and clear in the same cycle");

endmodule

// ==== design/mem_1r1w.sv ====
`timescale 1ns/1ps

`include "be_config.svh"

module mem_1r1w
  #(parameter type data_t = logic [31:0]
  ,parameter int els_p = `BE_QUEUE_ELS
  ,localparam int addr_width_lp = $clog2(els_p)
  )
  (input  logic                      clk_i

  ,input  logic                      w_v_i
  ,input  logic [addr_width_lp-1:0]  w_addr_i
  ,input  data_t                     w_data_i

  ,input  logic [addr_width_lp-1:0]  r_addr_i
  ,output data_t                     r_data_o
  );

  data_t mem_r [els_p];

  always_ff @(posedge clk_i)
  begin
    if (w_v_i)
      mem_r[w_addr_i] <= w_data_i;
  end

  // read is asynchronous so the head shows up in the cycle after a write
  assign r_data_o = mem_r[r_addr_i];

  a_depth_pow2: assert property (@(posedge clk_i) (els_p == (1 << addr_width_lp)))
    else $error("memory depth must be a power of two");

endmodule

// ==== design/be_predecode.sv ====
`timescale 1ns/1ps

module be_predecode
  (input  be_types_pkg::be_msg_e        msg_i
  ,input  logic [31:0]                  instr_i
  ,output be_types_pkg::be_issue_pkt_s  pkt_o
  );

  import rv64_isa_pkg::*;
  import be_types_pkg::*;

  rv64_instr_s instr;
  logic [6:0]  funct7;
  logic [4:0]  funct5;
  logic        muldiv;

  assign instr  = instr_i;
  assign funct7 = {instr.rs3_addr, instr.funct2};
  assign funct5 = instr.rs3_addr;
  assign muldiv = (funct7 == rv64_funct7_muldiv)
                  & (instr.opcode inside {rv64_op_op, rv64_op_32_op});

  always_comb
  begin
    pkt_o = '0; // non-fetch messages carry no instruction

    if (msg_i == e_instr_fetch)
    begin
      pkt_o.csr_v   = (instr.opcode == rv64_system_op);
      pkt_o.mem_v   = instr.opcode inside {rv64_load_op, rv64_store_op
                                          ,rv64_fload_op, rv64_fstore_op
                                          ,rv64_amo_op, rv64_system_op};
      pkt_o.fence_v = (instr.opcode == rv64_misc_mem_op)
                      | ((instr.opcode == rv64_system_op)
                         & (funct7 == rv64_funct7_sfence_vma)
                         & (instr.funct3 == rv64_funct3_priv));

      // div and rem have funct3 msb set, mulh variants sit below them
      pkt_o.long_v  = (muldiv & instr.funct3[2])
                      | (muldiv & (instr.opcode == rv64_op_op)
                         & (instr.funct3 inside {3'b001, 3'b010, 3'b011}))
                      | ((instr.opcode == rv64_fp_op)
                         & (funct5 inside {rv64_funct5_fdiv, rv64_funct5_fsqrt}));

      //////////////////////////////
      // register file reads

      case (instr.opcode)
        rv64_jalr_op, rv64_load_op, rv64_op_imm_op, rv64_op_imm_32_op, rv64_system_op,
        rv64_fload_op:
        begin
          pkt_o.irs1_v = 1'b1;
        end
        rv64_branch_op, rv64_store_op, rv64_op_op, rv64_op_32_op, rv64_amo_op:
        begin
          pkt_o.irs1_v = 1'b1;
          pkt_o.irs2_v = 1'b1;
        end
        rv64_fstore_op:
        begin
          pkt_o.irs1_v = 1'b1; // address from the integer side
          pkt_o.frs2_v = 1'b1;
        end
        rv64_fp_op:
        begin
          if (funct5 inside {rv64_funct5_fcvt_to_int, rv64_funct5_fmv_to_int
                            ,rv64_funct5_fclass, rv64_funct5_fcvt_fp, rv64_funct5_fsqrt})
            pkt_o.frs1_v = 1'b1;
          else if (funct5 inside {rv64_funct5_fcvt_from_int, rv64_funct5_fmv_from_int})
            pkt_o.irs1_v = 1'b1;
          else
          begin
            pkt_o.frs1_v = 1'b1;
            pkt_o.frs2_v = 1'b1;
          end
        end
        rv64_fmadd_op, rv64_fmsub_op, rv64_fnmsub_op, rv64_fnmadd_op:
        begin
          pkt_o.frs1_v = 1'b1;
          pkt_o.frs2_v = 1'b1;
          pkt_o.frs3_v = 1'b1;
        end
        default:
        begin
          pkt_o.irs1_v = 1'b0; // lui, auipc, jal and misc_mem read nothing
        end
      endcase

      pkt_o.rs1_addr = instr.rs1_addr;
      pkt_o.rs2_addr = instr.rs2_addr;
      pkt_o.rs3_addr = instr.rs3_addr;
    end
  end

endmodule

// ==== common/be_types_pkg.sv ====
package be_types_pkg;

  // kind of entry handed over by the fetch side
  typedef enum logic [1:0] {
    e_instr_fetch = 2'b00,
    e_exception   = 2'b01,
    e_itlb_fill   = 2'b10
  } be_msg_e;

  //////////////////////////////
  // issue packet

  typedef struct packed {
    logic       csr_v;   // touches a csr
    logic       mem_v;
    logic       fence_v;
    logic       long_v;  // goes to the long latency pipe
    logic       irs1_v;
    logic       irs2_v;
    logic       frs1_v;
    logic       frs2_v;
    logic       frs3_v;
    logic [4:0] rs1_addr;
    logic [4:0] rs2_addr;
    logic [4:0] rs3_addr;
  } be_issue_pkt_s;

endpackage

// ==== common/rv64_isa_pkg.sv ====
package rv64_isa_pkg;

  //////////////////////////////
  // major opcodes

  localparam logic [6:0] rv64_load_op      = 7'b0000011;
  localparam logic [6:0] rv64_store_op     = 7'b0100011;
  localparam logic [6:0] rv64_fload_op     = 7'b0000111;
  localparam logic [6:0] rv64_fstore_op    = 7'b0100111;
  localparam logic [6:0] rv64_amo_op       = 7'b0101111;
  localparam logic [6:0] rv64_system_op    = 7'b1110011;
  localparam logic [6:0] rv64_branch_op    = 7'b1100011;
  localparam logic [6:0] rv64_jalr_op      = 7'b1100111;
  localparam logic [6:0] rv64_op_imm_op    = 7'b0010011;
  localparam logic [6:0] rv64_op_imm_32_op = 7'b0011011;
  localparam logic [6:0] rv64_op_op        = 7'b0110011;
  localparam logic [6:0] rv64_op_32_op     = 7'b0111011;
  localparam logic [6:0] rv64_fp_op        = 7'b1010011;
  localparam logic [6:0] rv64_fmadd_op     = 7'b1000011;
  localparam logic [6:0] rv64_fmsub_op     = 7'b1000111;
  localparam logic [6:0] rv64_fnmsub_op    = 7'b1001011;
  localparam logic [6:0] rv64_fnmadd_op    = 7'b1001111;
  localparam logic [6:0] rv64_misc_mem_op  = 7'b0001111;

  //////////////////////////////
  // function codes

  localparam logic [6:0] rv64_funct7_muldiv     = 7'b0000001;
  localparam logic [6:0] rv64_funct7_sfence_vma = 7'b0001001;
  localparam logic [2:0] rv64_funct3_priv       = 3'b000;

  // fp_op groups are told apart by the top five bits of funct7
  localparam logic [4:0] rv64_funct5_fcvt_to_int   = 5'b11000;
  localparam logic [4:0] rv64_funct5_fcvt_from_int = 5'b11010;
  localparam logic [4:0] rv64_funct5_fcvt_fp       = 5'b01000;
  localparam logic [4:0] rv64_funct5_fmv_to_int    = 5'b11100;
  localparam logic [4:0] rv64_funct5_fmv_from_int  = 5'b11110;
  localparam logic [4:0] rv64_funct5_fclass        = 5'b11100; // shares a code with fmv.x
  localparam logic [4:0] rv64_funct5_fdiv          = 5'b00011;
  localparam logic [4:0] rv64_funct5_fsqrt         = 5'b01011;

  //////////////////////////////
  // instruction fields

  // r4 layout, which also covers the r, i and s source fields
  typedef struct packed {
    logic [4:0] rs3_addr;
    logic [1:0] funct2;
    logic [4:0] rs2_addr;
    logic [4:0] rs1_addr;
    logic [2:0] funct3;
    logic [4:0] rd_addr;
    logic [6:0] opcode;
  } rv64_instr_s;

endpackage

// ==== common/be_config.svh ====
`ifndef BE_CONFIG_SVH
`define BE_CONFIG_SVH

// queue depth in entries, a power of two
`define BE_QUEUE_ELS 8

// log2 of the queue depth
`define BE_PTR_WIDTH 3

`define BE_VADDR_WIDTH 39

`endif
